// ==== Makefile ====
TOP := tb_lynx_video

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f build.f --top-module $(TOP)

# pass only when the simulator prints the pass line
run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

lint:
	verilator --lint-only --timing --assert -f build.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// ==== build.f ====
hdl/video_pkg.sv
hdl/raster_pkg.sv
hdl/video_ifs.sv
hdl/raster_timing.sv
hdl/frame_store.sv
hdl/flicker_blend.sv
hdl/video_out.sv
hdl/lynx_video_top.sv
sim/tb_lynx_video.sv

// ==== hdl/flicker_blend.sv ====
`timescale 1ns/1ns
`default_nettype none

module flicker_blend (
  input  logic                   clk_sys,
  input  logic                   rst_n,
  input  video_pkg::blend_mode_t blend_mode,
  fb_read_if.sink                rd,
  mixed_if.source                mix
);

  video_pkg::rgb444_t now_px;
  video_pkg::rgb444_t last_px;
  logic [4:0]         r2, g2, b2;
  logic [5:0]         r3, g3, b3;
  video_pkg::rgb888_t blended;

  function automatic video_pkg::rgb444_t pick(
    input video_pkg::buf_idx_t                             idx,
    input video_pkg::rgb444_t [video_pkg::NUM_BUFFERS-1:0] rgb
  );
    case (idx)
      2'd1:    return rgb[1];
      2'd2:    return rgb[2];
      default: return rgb[0];
    endcase
  endfunction

  // 6-bit sum of three frames, widened and scaled back to 8 bits
  function automatic logic [7:0] scale3(input logic [5:0] t);
    logic [7:0]  t8;
    logic [23:0] prod;
    t8   = {t, t[5:4]};
    prod = 24'(t8) * 24'(video_pkg::BLEND3_MUL);
    return prod[video_pkg::BLEND3_SHIFT +: 8];
  endfunction

  always_comb begin
    now_px  = pick(rd.idx_now, rd.rgb);
    last_px = pick(rd.idx_last, rd.rgb);
    r2 = {1'b0, now_px.r} + {1'b0, last_px.r};
    g2 = {1'b0, now_px.g} + {1'b0, last_px.g};
    b2 = {1'b0, now_px.b} + {1'b0, last_px.b};
    r3 = {2'b00, rd.rgb[0].r} + {2'b00, rd.rgb[1].r} + {2'b00, rd.rgb[2].r};
    g3 = {2'b00, rd.rgb[0].g} + {2'b00, rd.rgb[1].g} + {2'b00, rd.rgb[2].g};
    b3 = {2'b00, rd.rgb[0].b} + {2'b00, rd.rgb[1].b} + {2'b00, rd.rgb[2].b};
    case (blend_mode)
      video_pkg::blend_off: blended = '{r: {now_px.r, now_px.r},
                                        g: {now_px.g, now_px.g},
                                        b: {now_px.b, now_px.b}};
      video_pkg::blend_two: blended = '{r: {r2, r2[4:2]}, g: {g2, g2[4:2]}, b: {b2, b2[4:2]}};
      default:              blended = '{r: scale3(r3), g: scale3(g3), b: scale3(b3)};
    endcase
  end

  always_ff @(posedge clk_sys or negedge rst_n) begin
    if (!rst_n) begin
      mix.ce     <= 1'b0;
      mix.active <= 1'b0;
      mix.hs     <= 1'b0;
      mix.vs     <= 1'b0;
    end else begin
      mix.ce     <= rd.ce;
      mix.active <= rd.active;
      mix.hs     <= rd.hs;
      mix.vs     <= rd.vs;
    end
  end

  always_ff @(posedge clk_sys) begin
    mix.rgb888 <= blended;
  end

endmodule

`default_nettype wire

// ==== hdl/frame_store.sv ====
`timescale 1ns/1ns
`default_nettype none

module frame_store #(
  parameter int H_ACTIVE = raster_pkg::DEF_H_ACTIVE,
  parameter int V_ACTIVE = raster_pkg::DEF_V_ACTIVE
) (
  input  logic                          clk_sys,
  input  logic                          rst_n,
  input  logic                          pixel_we,
  input  logic [raster_pkg::ADDR_W-1:0] pixel_addr,
  input  video_pkg::rgb444_t            pixel_data,
  input  logic                          buffer_en,
  input  video_pkg::blend_mode_t        blend_mode,
  raster_if.sink                        rast,
  fb_read_if.source                     rd
);

  localparam int AW = raster_pkg::ADDR_W;
  localparam logic [AW-1:0] LAST_ADDR = AW'(H_ACTIVE * V_ACTIVE - 1);
  localparam video_pkg::buf_idx_t LAST_IDX = video_pkg::buf_idx_t'(video_pkg::NUM_BUFFERS - 1);

  logic                buffering;
  logic                frame_done;
  video_pkg::buf_idx_t idx_wr;
  video_pkg::buf_idx_t idx_next;
  video_pkg::buf_idx_t idx_now;
  video_pkg::buf_idx_t idx_last;

  // 3-frame blend needs all buffers filled in turn
  assign buffering  = buffer_en || (blend_mode == video_pkg::blend_three);
  assign frame_done = pixel_we && (pixel_addr == LAST_ADDR);

  ////////////////////////////////////////////////////////////////////////////
  // write side

  always_ff @(posedge clk_sys or negedge rst_n) begin
    if (!rst_n) begin
      idx_wr   <= '0;
      idx_next <= '0;
    end else if (!buffering) begin
      idx_wr   <= '0;
      idx_next <= '0;
    end else if (frame_done) begin
      // finished buffer becomes the next one to show
      idx_next <= idx_wr;
      idx_wr   <= (idx_wr == LAST_IDX) ? '0 : idx_wr + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // read side

  always_ff @(posedge clk_sys or negedge rst_n) begin
    if (!rst_n) begin
      idx_now  <= '0;
      idx_last <= '0;
    end else if (rast.frame_end) begin
      idx_last <= idx_now;
      idx_now  <= idx_next;
    end
  end

  for (genvar i = 0; i < video_pkg::NUM_BUFFERS; i++) begin : g_buf
    video_pkg::rgb444_t mem [2**AW];
    video_pkg::rgb444_t q;

    always_ff @(posedge clk_sys) begin
      if (pixel_we && (idx_wr == video_pkg::buf_idx_t'(i))) begin
        mem[pixel_addr] <= pixel_data;
      end
      q <= mem[rast.px_addr];
    end

    assign rd.rgb[i] = q;
  end

  // control follows the read data by one clock
  always_ff @(posedge clk_sys or negedge rst_n) begin
    if (!rst_n) begin
      rd.ce     <= 1'b0;
      rd.active <= 1'b0;
      rd.hs     <= 1'b0;
      rd.vs     <= 1'b0;
    end else begin
      rd.ce     <= rast.ce;
      rd.active <= rast.active;
      rd.hs     <= rast.hs;
      rd.vs     <= rast.vs;
    end
  end

  assign rd.idx_now  = idx_now;
  assign rd.idx_last = idx_last;

  a_wr_in_frame: assert property (@(posedge clk_sys) disable iff (!rst_n)
    pixel_we |-> (pixel_addr <= LAST_ADDR))
    else $error("pixel write beyond the last frame address");

  a_idx_legal: assert property (@(posedge clk_sys) disable iff (!rst_n)
    (idx_wr != 2'd3) && (idx_next != 2'd3) && (idx_now != 2'd3) && (idx_last != 2'd3))
    else $error("buffer index out of range");

endmodule

`default_nettype wire

// ==== hdl/lynx_video_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module lynx_video_top #(
  parameter int H_ACTIVE = raster_pkg::DEF_H_ACTIVE,
  parameter int V_ACTIVE = raster_pkg::DEF_V_ACTIVE,
  parameter int H_TOTAL  = raster_pkg::DEF_H_TOTAL,
  parameter int V_TOTAL  = raster_pkg::DEF_V_TOTAL,
  parameter int V_START  = raster_pkg::DEF_V_START,
  parameter int PIX_DIV  = raster_pkg::DEF_PIX_DIV
) (
  input  logic                          clk_sys,
  input  logic                          rst_n,
  input  logic                          pixel_we,
  input  logic [raster_pkg::ADDR_W-1:0] pixel_addr,
  input  logic [11:0]                   pixel_data,
  input  logic                          buffer_en,
  input  logic [1:0]                    blend_mode,
  input  logic                          gray_en,
  output logic [23:0]                   video_rgb,
  output logic                          video_de,
  output logic                          video_hs,
  output logic                          video_vs
);

  video_pkg::blend_mode_t mode;

  assign mode = video_pkg::blend_mode_t'(blend_mode);

  raster_if  rast ();
  fb_read_if rd ();
  mixed_if   mix ();

  // raster -> frame store -> blend -> output, three clocks from ce to de
  raster_timing #(
    .H_ACTIVE (H_ACTIVE),
    .V_ACTIVE (V_ACTIVE),
    .H_TOTAL  (H_TOTAL),
    .V_TOTAL  (V_TOTAL),
    .V_START  (V_START),
    .PIX_DIV  (PIX_DIV)
  ) u_raster (.clk_sys(clk_sys), .rst_n(rst_n), .rast(rast));

  frame_store #(
    .H_ACTIVE (H_ACTIVE),
    .V_ACTIVE (V_ACTIVE)
  ) u_store (
    .clk_sys    (clk_sys),
    .rst_n      (rst_n),
    .pixel_we   (pixel_we),
    .pixel_addr (pixel_addr),
    .pixel_data (pixel_data),
    .buffer_en  (buffer_en),
    .blend_mode (mode),
    .rast       (rast),
    .rd         (rd)
  );

  flicker_blend u_blend (.clk_sys(clk_sys), .rst_n(rst_n), .blend_mode(mode), .rd(rd), .mix(mix));

  video_out u_out (
    .clk_sys   (clk_sys),
    .rst_n     (rst_n),
    .gray_en   (gray_en),
    .mix       (mix),
    .video_rgb (video_rgb),
    .video_de  (video_de),
    .video_hs  (video_hs),
    .video_vs  (video_vs)
  );

endmodule

`default_nettype wire

// ==== hdl/raster_pkg.sv ====
`default_nettype none

package raster_pkg;

  localparam int COORD_W = 9;
  localparam int ADDR_W  = 14;

  // sync placement on the full raster
  localparam int HS_START     = 350;
  localparam int HS_WIDTH     = 32;
  localparam int VS_FIRST_ROW = 1;
  localparam int VS_LAST_ROW  = 4;
  localparam int HS_DELAY     = 7;

  // landscape 160x102 scan, about 60 Hz at the divided pixel rate
  localparam int DEF_H_ACTIVE = 160;
  localparam int DEF_V_ACTIVE = 102;
  localparam int DEF_H_TOTAL  = 445;
  localparam int DEF_V_TOTAL  = 270;
  localparam int DEF_V_START  = 120;
  localparam int DEF_PIX_DIV  = 9;

endpackage

`default_nettype wire

// ==== hdl/raster_timing.sv ====
`timescale 1ns/1ns
`default_nettype none

module raster_timing #(
  parameter int H_ACTIVE = raster_pkg::DEF_H_ACTIVE,
  parameter int V_ACTIVE = raster_pkg::DEF_V_ACTIVE,
  parameter int H_TOTAL  = raster_pkg::DEF_H_TOTAL,
  parameter int V_TOTAL  = raster_pkg::DEF_V_TOTAL,
  parameter int V_START  = raster_pkg::DEF_V_START,
  parameter int PIX_DIV  = raster_pkg::DEF_PIX_DIV
) (
  input  logic     clk_sys,
  input  logic     rst_n,
  raster_if.source rast
);

  localparam int CW    = raster_pkg::COORD_W;
  localparam int DIV_W = (PIX_DIV > 1) ? $clog2(PIX_DIV) : 1;
  // short rasters put hsync right after the active area
  localparam int HS_COL = (raster_pkg::HS_START < H_TOTAL) ? raster_pkg::HS_START : H_ACTIVE;
  localparam int HS_END = (HS_COL + raster_pkg::HS_WIDTH < H_TOTAL) ?
                          HS_COL + raster_pkg::HS_WIDTH : H_TOTAL - 1;

  logic [DIV_W-1:0]              div;
  logic                          ce;
  logic [CW-1:0]                 x;
  logic [CW-1:0]                 y;
  logic                          hs;
  logic                          vs;
  logic [raster_pkg::ADDR_W-1:0] px_addr;
  logic                          h_active;
  logic                          v_active;

  assign h_active = (x < CW'(H_ACTIVE));
  assign v_active = (y >= CW'(V_START)) && (y < CW'(V_START + V_ACTIVE));

  // pixel enable, one clock in PIX_DIV
  always_ff @(posedge clk_sys or negedge rst_n) begin
    if (!rst_n) begin
      div <= '0;
      ce  <= 1'b0;
    end else begin
      ce <= (div == DIV_W'(PIX_DIV - 1));
      if (div == DIV_W'(PIX_DIV - 1)) begin
        div <= '0;
      end else begin
        div <= div + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_sys or negedge rst_n) begin
    if (!rst_n) begin
      x       <= '0;
      y       <= '0;
      hs      <= 1'b0;
      vs      <= 1'b0;
      px_addr <= '0;
    end else if (ce) begin
      if (x == CW'(H_TOTAL - 1)) begin
        x <= '0;
        y <= (y == CW'(V_TOTAL - 1)) ? '0 : y + 1'b1;
      end else begin
        x <= x + 1'b1;
      end
      // vsync edges line up with the start of hsync
      if (x == CW'(HS_COL)) begin
        hs <= 1'b1;
        if (y == CW'(raster_pkg::VS_FIRST_ROW)) vs <= 1'b1;
        if (y == CW'(raster_pkg::VS_LAST_ROW))  vs <= 1'b0;
      end
      if (x == CW'(HS_END)) hs <= 1'b0;
      // row-major scan of the stored frame
      if (!v_active) begin
        px_addr <= '0;
      end else if (h_active) begin
        px_addr <= px_addr + 1'b1;
      end
    end
  end

  assign rast.ce        = ce;
  assign rast.px_addr   = px_addr;
  assign rast.active    = h_active && v_active;
  assign rast.hs        = hs;
  assign rast.vs        = vs;
  assign rast.frame_end = ce && (x == '0) && (y == CW'(V_TOTAL - 1));

  a_ce_single: assert property (@(posedge clk_sys) disable iff (!rst_n) ce |=> !ce)
    else $error("pixel enable high on two clocks in a row");

endmodule

`default_nettype wire

// ==== hdl/video_ifs.sv ====
`timescale 1ns/1ns
`default_nettype none

// scan position and sync from the raster generator
interface raster_if;
  logic                          ce;
  logic [raster_pkg::ADDR_W-1:0] px_addr;
  logic                          active;
  logic                          hs;
  logic                          vs;
  logic                          frame_end;

  modport source (output ce, px_addr, active, hs, vs, frame_end);
  modport sink   (input  ce, px_addr, active, hs, vs, frame_end);
endinterface

// all three buffers at the scan address, plus the display indices
interface fb_read_if;
  video_pkg::rgb444_t [video_pkg::NUM_BUFFERS-1:0] rgb;
  video_pkg::buf_idx_t                             idx_now;
  video_pkg::buf_idx_t                             idx_last;
  logic                                            ce;
  logic                                            active;
  logic                                            hs;
  logic                                            vs;

  modport source (output rgb, idx_now, idx_last, ce, active, hs, vs);
  modport sink   (input  rgb, idx_now, idx_last, ce, active, hs, vs);
endinterface

// blended pixel on its way to the output stage
interface mixed_if;
  video_pkg::rgb888_t rgb888;
  logic               ce;
  logic               active;
  logic               hs;
  logic               vs;

  modport source (output rgb888, ce, active, hs, vs);
  modport sink   (input  rgb888, ce, active, hs, vs);
endinterface

`default_nettype wire

// ==== hdl/video_out.sv ====
`timescale 1ns/1ns
`default_nettype none

module video_out (
  input  logic        clk_sys,
  input  logic        rst_n,
  input  logic        gray_en,
  mixed_if.sink       mix,
  output logic [23:0] video_rgb,
  output logic        video_de,
  output logic        video_hs,
  output logic        video_vs
);

  localparam int DLY_W = $clog2(raster_pkg::HS_DELAY + 1);

  logic               de;
  logic               hs_prev;
  logic               vs_prev;
  logic [DLY_W-1:0]   hs_cnt;
  logic [15:0]        luma_sum;
  logic [7:0]         luma;
  video_pkg::rgb888_t px;

  assign de = mix.ce && mix.active;

  // weighted sum peaks at 25500
  always_comb begin
    luma_sum = 16'(video_pkg::LUMA_R) * 16'(mix.rgb888.r)
             + 16'(video_pkg::LUMA_G) * 16'(mix.rgb888.g)
             + 16'(video_pkg::LUMA_B) * 16'(mix.rgb888.b);
    luma = 8'(luma_sum / 16'(video_pkg::LUMA_DIV));
    px   = gray_en ? video_pkg::rgb888_t'{r: luma, g: luma, b: luma} : mix.rgb888;
  end

  always_ff @(posedge clk_sys or negedge rst_n) begin
    if (!rst_n) begin
      video_de  <= 1'b0;
      video_rgb <= '0;
      video_hs  <= 1'b0;
      video_vs  <= 1'b0;
      hs_prev   <= 1'b0;
      vs_prev   <= 1'b0;
      hs_cnt    <= '0;
    end else begin
      video_de  <= de;
      video_rgb <= de ? px : '0;
      // vsync pulse on the rising edge
      video_vs  <= mix.vs && !vs_prev;
      vs_prev   <= mix.vs;
      hs_prev   <= mix.hs;
      // hsync held back so it never lands on the vsync clock
      video_hs  <= (hs_cnt == DLY_W'(1));
      if (mix.hs && !hs_prev) begin
        hs_cnt <= DLY_W'(raster_pkg::HS_DELAY);
      end else if (hs_cnt != '0) begin
        hs_cnt <= hs_cnt - 1'b1;
      end
    end
  end

  a_sync_apart: assert property (@(posedge clk_sys) disable iff (!rst_n)
    !(video_hs && video_vs))
    else $error("hsync and vsync pulses overlap");

endmodule

`default_nettype wire

// ==== hdl/video_pkg.sv ====
`default_nettype none

package video_pkg;

  // pixel as stored in the frame buffers
  typedef struct packed {
    logic [3:0] r;
    logic [3:0] g;
    logic [3:0] b;
  } rgb444_t;

  // pixel as sent to the scaler
  typedef struct packed {
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
  } rgb888_t;

  typedef enum logic [1:0] {
    blend_off   = 2'd0,
    blend_two   = 2'd1,
    blend_three = 2'd2
  } blend_mode_t;

  // buffer number, 0 to 2
  typedef logic [1:0] buf_idx_t;

  localparam int NUM_BUFFERS = 3;

  // grayscale weights, percent
  localparam int LUMA_R   = 21;
  localparam int LUMA_G   = 72;
  localparam int LUMA_B   = 7;
  localparam int LUMA_DIV = 100;

  // 3-frame mix, roughly x4/3 then >>14
  localparam int BLEND3_MUL   = 21845;
  localparam int BLEND3_SHIFT = 14;

endpackage

`default_nettype wire

// ==== sim/tb_lynx_video.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_lynx_video;

  localparam int H_ACTIVE   = 8;
  localparam int V_ACTIVE   = 4;
  localparam int H_TOTAL    = 16;
  localparam int V_TOTAL    = 10;
  localparam int V_START    = 2;
  localparam int PIX_DIV    = 3;
  localparam int FRAME_PX   = H_ACTIVE * V_ACTIVE;
  localparam int FRAME_CLKS = H_TOTAL * V_TOTAL * PIX_DIV;
  localparam int MAX_CASES  = 32;
  localparam int COLS       = 5;

  logic        clk_sys;
  logic        rst_n;
  logic        pixel_we;
  logic [13:0] pixel_addr;
  logic [11:0] pixel_data;
  logic        buffer_en;
  logic [1:0]  blend_mode;
  logic        gray_en;
  logic [23:0] video_rgb;
  logic        video_de;
  logic        video_hs;
  logic        video_vs;

  // reference model of the three buffers and the display indices
  logic [11:0] model_mem [3][FRAME_PX];
  int          m_wr;
  int          m_next;
  int          m_now;
  int          m_last;
  bit          model_buf;
  int          vs_count;
  logic [31:0] lcg_state;
  logic [7:0]  case_data [MAX_CASES*COLS];
  int          n_cases;
  logic        vs_prev = 1'b0;
  bit          vs_twice;

  lynx_video_top #(
    .H_ACTIVE (H_ACTIVE),
    .V_ACTIVE (V_ACTIVE),
    .H_TOTAL  (H_TOTAL),
    .V_TOTAL  (V_TOTAL),
    .V_START  (V_START),
    .PIX_DIV  (PIX_DIV)
  ) DUT (
    .clk_sys    (clk_sys),
    .rst_n      (rst_n),
    .pixel_we   (pixel_we),
    .pixel_addr (pixel_addr),
    .pixel_data (pixel_data),
    .buffer_en  (buffer_en),
    .blend_mode (blend_mode),
    .gray_en    (gray_en),
    .video_rgb  (video_rgb),
    .video_de   (video_de),
    .video_hs   (video_hs),
    .video_vs   (video_vs)
  );

  always #5 clk_sys = ~clk_sys;

  ////////////////////////////////////////////////////////////////////////////
  // reporting

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("test failed");
    $fatal(1, "%s", msg);
  endtask

  task automatic check(input string name, input logic [23:0] expected,
                       input logic [23:0] actual);
    if (actual !== expected) begin
      $display("[ERROR] %0t ns %s expected %h actual %h", $time, name, expected, actual);
      $display("test failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic check_idle();
    check("video_de", 24'h0, 24'(video_de));
    check("video_hs", 24'h0, 24'(video_hs));
    check("video_vs", 24'h0, 24'(video_vs));
    check("video_rgb", 24'h0, video_rgb);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus and expected pixels

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // channel 0 is red, 2 is blue
  function automatic int chan(input logic [11:0] px, input int i);
    return int'((px >> (8 - 4 * i)) & 12'hf);
  endfunction

  function automatic logic [23:0] expected_px(input int mode, input bit gray, input int addr);
    int ch [3];
    int i;
    int s;
    int t;
    int y;
    for (i = 0; i < 3; i++) begin
      if (mode == 0) begin
        ch[i] = chan(model_mem[m_now][addr], i) * 17;
      end else if (mode == 1) begin
        s = chan(model_mem[m_now][addr], i) + chan(model_mem[m_last][addr], i);
        ch[i] = s * 8 + s / 4;
      end else begin
        t = chan(model_mem[0][addr], i) + chan(model_mem[1][addr], i)
          + chan(model_mem[2][addr], i);
        // widen to 8 bits, then scale by about 4/3
        ch[i] = ((t * 4 + t / 16) * 21845 / 16384) % 256;
      end
    end
    y = (21 * ch[0] + 72 * ch[1] + 7 * ch[2]) / 100;
    if (gray) begin
      return {8'(y), 8'(y), 8'(y)};
    end else begin
      return {8'(ch[0]), 8'(ch[1]), 8'(ch[2])};
    end
  endfunction

  task automatic load_cases();
    int i;
    for (i = 0; i < MAX_CASES * COLS; i++) begin
      case_data[i] = 8'hff;
    end
    $readmemh("sim/video_cases.txt", case_data);
    n_cases = 0;
    while (n_cases < MAX_CASES && case_data[n_cases * COLS] != 8'hff) begin
      n_cases++;
    end
    if (n_cases == 0) begin
      abort_run("no test cases could be read from sim/video_cases.txt");
    end
  endtask

  task automatic apply_settings(input int mode, input bit buf_en, input bit gray);
    blend_mode = 2'(mode);
    buffer_en  = buf_en;
    gray_en    = gray;
    // 3-frame blend forces buffering
    model_buf  = buf_en || (mode == 2);
    if (!model_buf) begin
      m_wr   = 0;
      m_next = 0;
    end
    // index hold settles before the first write
    @(negedge clk_sys);
  endtask

  task automatic write_frame();
    int a;
    for (a = 0; a < FRAME_PX; a++) begin
      lcg_state  = lcg_next(lcg_state);
      pixel_we   = 1'b1;
      pixel_addr = 14'(a);
      pixel_data = lcg_state[27:16];
      model_mem[m_wr][a] = lcg_state[27:16];
      // last address completes the frame
      if (a == FRAME_PX - 1 && model_buf) begin
        m_next = m_wr;
        m_wr   = (m_wr + 1) % 3;
      end
      @(negedge clk_sys);
    end
    pixel_we = 1'b0;
  endtask

  // every vsync but the first one follows a frame_end
  task automatic vs_seen();
    if (vs_count > 0) begin
      m_last = m_now;
      m_now  = m_next;
    end
    vs_count++;
  endtask

  task automatic next_vs();
    @(negedge clk_sys);
    while (video_vs !== 1'b1) begin
      @(negedge clk_sys);
    end
    vs_seen();
  endtask

  task automatic check_frame(input int mode, input bit gray, input int exp_de);
    int de_count;
    int hs_count;
    de_count = 0;
    hs_count = 0;
    @(negedge clk_sys);
    while (video_vs !== 1'b1) begin
      if (video_hs === 1'b1) begin
        hs_count++;
      end
      if (video_de === 1'b1) begin
        if (de_count < FRAME_PX) begin
          check("video_rgb", expected_px(mode, gray, de_count), video_rgb);
        end
        de_count++;
      end
      @(negedge clk_sys);
    end
    vs_seen();
    check("video_de per frame", 24'(exp_de), 24'(de_count));
    check("video_hs per frame", 24'(V_TOTAL), 24'(hs_count));
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // run

  always @(negedge clk_sys) begin
    vs_twice = (video_vs === 1'b1) && (vs_prev === 1'b1);
    vs_prev  = video_vs;
    if (rst_n === 1'b1) begin
      if (video_de !== 1'b1) begin
        check("video_rgb outside de", 24'h0, video_rgb);
      end
      if (video_hs === 1'b1 && video_vs === 1'b1) begin
        abort_run("video_hs and video_vs were high on the same clock");
      end
      if (vs_twice) begin
        abort_run("video_vs stayed high for more than one clock");
      end
    end
  end

  initial begin
    wait (n_cases > 0);
    #(longint'(n_cases) * 10 * FRAME_CLKS * 10);
    abort_run("timeout while waiting for the video output");
  end

  initial begin
    int c;
    int f;
    int base;
    clk_sys     = 1'b0;
    rst_n       = 1'b0;
    pixel_we    = 1'b0;
    pixel_addr  = '0;
    pixel_data  = '0;
    buffer_en   = 1'b0;
    blend_mode  = 2'd0;
    gray_en     = 1'b0;
    m_wr        = 0;
    m_next      = 0;
    m_now       = 0;
    m_last      = 0;
    model_buf   = 1'b0;
    vs_count    = 0;
    lcg_state   = 32'h175c;
    load_cases();

    // outputs quiet in reset and just after
    repeat (5) begin
      @(negedge clk_sys);
      check_idle();
    end
    rst_n = 1'b1;
    repeat (5) begin
      @(negedge clk_sys);
      check_idle();
    end

    next_vs();
    for (c = 0; c < n_cases; c++) begin
      base = c * COLS;
      apply_settings(int'(case_data[base]), case_data[base+1][0], case_data[base+2][0]);
      for (f = 0; f < int'(case_data[base+3]); f++) begin
        if (f > 0) begin
          next_vs();
        end
        write_frame();
      end
      // buffer picked at frame_end shows after the next vsync
      next_vs();
      check_frame(int'(case_data[base]), case_data[base+2][0], int'(case_data[base+4]));
    end

    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim/video_cases.txt ====
// columns (hex): blend_mode buffer_en gray_en frames_written de_pulses_per_frame
// blend_mode 0 off, 1 two-frame, 2 three-frame
0 0 0 1 20
0 0 0 2 20
1 1 0 3 20
2 0 0 3 20
2 0 1 3 20
1 1 1 2 20
0 1 0 1 20
0 0 1 1 20
1 0 0 2 20
0 1 1 3 20
